//--- src/sort_macros.svh
`ifndef SORT_MACROS_SVH
`define SORT_MACROS_SVH

// Pair address width of one bank, two tuples per address
`define BANK_ADDR_WIDTH 6

`define KEY_WIDTH 16
`define PAYLOAD_WIDTH 16

// Length of the pre-sorted runs in a loaded stream
`define START_WIDTH 16

`endif

//--- src/sort_pkg.sv
`default_nettype none
`include "sort_macros.svh"

package sort_pkg;

    // One tuple word, ordered by raw value with the key in the upper bits
    typedef union packed {
        logic [`KEY_WIDTH+`PAYLOAD_WIDTH-1:0] raw;
        struct packed {
            logic [`KEY_WIDTH-1:0]     key;
            logic [`PAYLOAD_WIDTH-1:0] payload;
        } fields;
    } tuple_t;

    // Entry of a fetched even/odd pair
    typedef tuple_t tuple_pair_t;

endpackage

`default_nettype wire

//--- src/bank_if.sv
`default_nettype none
`include "sort_macros.svh"

interface bank_if;

    logic [`BANK_ADDR_WIDTH-1:0] read_addr;
    logic                        read_en;
    sort_pkg::tuple_t            even_rd;
    sort_pkg::tuple_t            odd_rd;

    logic [`BANK_ADDR_WIDTH-1:0] write_addr;
    logic                        write_en;
    sort_pkg::tuple_t            even_wr;
    sort_pkg::tuple_t            odd_wr;

    modport engine (
        output read_addr, read_en, write_addr, write_en, even_wr, odd_wr,
        input  even_rd, odd_rd
    );

    modport bank (
        input  read_addr, read_en, write_addr, write_en, even_wr, odd_wr,
        output even_rd, odd_rd
    );

endinterface

`default_nettype wire

//--- src/pair_bank.sv
`default_nettype none
`include "sort_macros.svh"

module pair_bank (
    input  wire logic                        clock,
    bank_if.bank                             port,
    input  wire logic                        load_en,
    input  wire logic [`BANK_ADDR_WIDTH-1:0] load_addr,
    input  wire sort_pkg::tuple_t            load_even,
    input  wire sort_pkg::tuple_t            load_odd,
    input  wire logic [`BANK_ADDR_WIDTH-1:0] host_addr,
    output sort_pkg::tuple_t                 host_even,
    output sort_pkg::tuple_t                 host_odd
);

    localparam int DEPTH = 2 ** `BANK_ADDR_WIDTH;

    sort_pkg::tuple_t even_mem [DEPTH];
    sort_pkg::tuple_t odd_mem [DEPTH];

    // Merge pass writes take priority over host loads
    always_ff @(posedge clock) begin
        if (port.write_en) begin
            even_mem[port.write_addr] <= port.even_wr;
            odd_mem[port.write_addr]  <= port.odd_wr;
        end else if (load_en) begin
            even_mem[load_addr] <= load_even;
            odd_mem[load_addr]  <= load_odd;
        end
    end

    // Engine read, data valid the cycle after read_en and held otherwise
    always_ff @(posedge clock) begin
        if (port.read_en) begin
            port.even_rd <= even_mem[port.read_addr];
            port.odd_rd  <= odd_mem[port.read_addr];
        end
    end

    // Host read, one cycle latency
    always_ff @(posedge clock) begin
        host_even <= even_mem[host_addr];
        host_odd  <= odd_mem[host_addr];
    end

endmodule

`default_nettype wire

//--- src/merge_phase.sv
`default_nettype none
`include "sort_macros.svh"

module merge_phase (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        start,
    input  wire logic [`BANK_ADDR_WIDTH+1:0] stream_len,
    bank_if.engine                           rd,
    bank_if.engine                           wr,
    output logic                             pingpong,
    output logic                             busy,
    output logic                             done
);

    // Pair counts need headroom above the bank depth for run end clamping
    localparam int CW = `BANK_ADDR_WIDTH + 2;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_SETUP = 2'd1;
    localparam logic [1:0] ST_MERGE = 2'd2;

    localparam sort_pkg::tuple_t SENTINEL = '1;

    logic [1:0]                  state;
    logic [CW-1:0]               len_pairs;
    logic [CW-1:0]               width_pairs;
    logic [CW-1:0]               two_width;
    logic [CW-1:0]               base_ptr;
    logic [CW-1:0]               mid_sum;
    logic [CW-1:0]               end_sum;
    logic [CW-1:0]               fetch_ptr [2];
    logic [CW-1:0]               stop_ptr [2];
    logic [1:0]                  fill [2];
    sort_pkg::tuple_pair_t       front [2];
    sort_pkg::tuple_pair_t       back [2];
    logic                        pend_valid;
    logic                        pend_side;
    logic                        issue;
    logic                        issue_side;
    logic [1:0]                  waiting;
    logic [1:0]                  need;
    logic [1:0]                  exhausted;
    logic [1:0]                  ready;
    logic                        emit;
    logic                        take_left;
    logic                        group_end;
    sort_pkg::tuple_t            winner;
    sort_pkg::tuple_t            stage;
    logic                        stage_sel;
    logic [`BANK_ADDR_WIDTH-1:0] pair_cnt;

    // All pointer arithmetic is in pair units
    assign len_pairs = {1'b0, stream_len[CW-1:1]};
    assign two_width = width_pairs << 1;
    assign mid_sum   = base_ptr + width_pairs;
    assign end_sum   = base_ptr + two_width;
    assign busy      = (state != ST_IDLE);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            waiting[s]   = pend_valid && (pend_side == 1'(s));
            exhausted[s] = (fill[s] == 2'd0) && (fetch_ptr[s] >= stop_ptr[s]) && !waiting[s];
            need[s]      = (state == ST_MERGE) && (fill[s] == 2'd0)
                           && (fetch_ptr[s] < stop_ptr[s]) && !waiting[s];
            ready[s]     = (fill[s] != 2'd0) || exhausted[s];
        end
    end

    // Left run has fetch priority, one read per cycle
    assign issue      = need[0] | need[1];
    assign issue_side = ~need[0];

    assign group_end = (state == ST_MERGE) && (&exhausted);
    assign emit      = (state == ST_MERGE) && (&ready) && !(&exhausted);
    assign take_left = exhausted[1] || (!exhausted[0] && front[0].raw <= front[1].raw);
    assign winner    = take_left ? front[0] : front[1];

    assign rd.read_en    = issue;
    assign rd.read_addr  = fetch_ptr[issue_side][`BANK_ADDR_WIDTH-1:0];
    assign rd.write_en   = 1'b0;
    assign rd.write_addr = '0;
    assign rd.even_wr    = '0;
    assign rd.odd_wr     = '0;
    assign wr.read_en    = 1'b0;
    assign wr.read_addr  = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            state         <= ST_IDLE;
            pingpong      <= 1'b0;
            done          <= 1'b0;
            width_pairs   <= '0;
            base_ptr      <= '0;
            fetch_ptr[0]  <= '0;
            fetch_ptr[1]  <= '0;
            stop_ptr[0]   <= '0;
            stop_ptr[1]   <= '0;
            fill[0]       <= 2'd0;
            fill[1]       <= 2'd0;
            pend_valid    <= 1'b0;
            pend_side     <= 1'b0;
            stage_sel     <= 1'b0;
            pair_cnt      <= '0;
            wr.write_en   <= 1'b0;
            wr.write_addr <= '0;
        end else begin
            pend_valid  <= issue;
            pend_side   <= issue_side;
            wr.write_en <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        // Already sorted when the start runs cover the stream
                        done        <= (`START_WIDTH >= stream_len);
                        pingpong    <= 1'b0;
                        width_pairs <= CW'(`START_WIDTH / 2);
                        base_ptr    <= '0;
                        pair_cnt    <= '0;
                        stage_sel   <= 1'b0;
                        if (`START_WIDTH < stream_len) begin
                            state <= ST_SETUP;
                        end
                    end
                end
                ST_SETUP: begin
                    fetch_ptr[0] <= base_ptr;
                    stop_ptr[0]  <= (mid_sum > len_pairs) ? len_pairs : mid_sum;
                    fetch_ptr[1] <= (mid_sum > len_pairs) ? len_pairs : mid_sum;
                    stop_ptr[1]  <= (end_sum > len_pairs) ? len_pairs : end_sum;
                    fill[0]      <= 2'd0;
                    fill[1]      <= 2'd0;
                    state        <= ST_MERGE;
                end
                ST_MERGE: begin
                    if (issue) begin
                        fetch_ptr[issue_side] <= fetch_ptr[issue_side] + 1'b1;
                    end
                    if (pend_valid) begin
                        fill[pend_side] <= 2'd2;
                    end
                    if (emit) begin
                        if (take_left) begin
                            fill[0] <= fill[0] - 2'd1;
                        end else begin
                            fill[1] <= fill[1] - 2'd1;
                        end
                        stage_sel <= ~stage_sel;
                        // Second tuple of a pair completes a write
                        if (stage_sel) begin
                            wr.write_en   <= 1'b1;
                            wr.write_addr <= pair_cnt;
                            pair_cnt      <= pair_cnt + 1'b1;
                        end
                    end
                    if (group_end) begin
                        if (end_sum >= len_pairs) begin
                            pingpong    <= ~pingpong;
                            width_pairs <= two_width;
                            base_ptr    <= '0;
                            pair_cnt    <= '0;
                            if (two_width >= len_pairs) begin
                                done  <= 1'b1;
                                state <= ST_IDLE;
                            end else begin
                                state <= ST_SETUP;
                            end
                        end else begin
                            base_ptr <= end_sum;
                            state    <= ST_SETUP;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Run buffers and pair staging
    always_ff @(posedge clock) begin
        if (state == ST_SETUP) begin
            front[0] <= SENTINEL;
            front[1] <= SENTINEL;
            back[0]  <= SENTINEL;
            back[1]  <= SENTINEL;
        end else begin
            if (pend_valid) begin
                front[pend_side] <= rd.even_rd;
                back[pend_side]  <= rd.odd_rd;
            end
            if (emit) begin
                if (take_left) begin
                    front[0] <= back[0];
                    back[0]  <= SENTINEL;
                end else begin
                    front[1] <= back[1];
                    back[1]  <= SENTINEL;
                end
                if (stage_sel) begin
                    wr.even_wr <= stage;
                    wr.odd_wr  <= winner;
                end else begin
                    stage <= winner;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/merge_sorter.sv
`default_nettype none
`include "sort_macros.svh"

module merge_sorter (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        load_en,
    input  wire logic [`BANK_ADDR_WIDTH-1:0] load_addr,
    input  wire sort_pkg::tuple_t            load_even,
    input  wire sort_pkg::tuple_t            load_odd,
    input  wire logic                        start,
    input  wire logic [`BANK_ADDR_WIDTH+1:0] stream_len,
    output logic                             busy,
    output logic                             done,
    input  wire logic [`BANK_ADDR_WIDTH-1:0] result_addr,
    output sort_pkg::tuple_t                 result_even,
    output sort_pkg::tuple_t                 result_odd
);

    logic             pingpong;
    sort_pkg::tuple_t a_host_even;
    sort_pkg::tuple_t a_host_odd;
    sort_pkg::tuple_t b_host_even;
    sort_pkg::tuple_t b_host_odd;

    bank_if eng_rd ();
    bank_if eng_wr ();
    bank_if bus_a ();
    bank_if bus_b ();

    merge_phase u_merge (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .stream_len (stream_len),
        .rd         (eng_rd.engine),
        .wr         (eng_wr.engine),
        .pingpong   (pingpong),
        .busy       (busy),
        .done       (done)
    );

    // pingpong low reads bank a and writes bank b
    assign bus_a.read_addr  = eng_rd.read_addr;
    assign bus_a.read_en    = eng_rd.read_en & ~pingpong;
    assign bus_a.write_addr = eng_wr.write_addr;
    assign bus_a.write_en   = eng_wr.write_en & pingpong;
    assign bus_a.even_wr    = eng_wr.even_wr;
    assign bus_a.odd_wr     = eng_wr.odd_wr;

    assign bus_b.read_addr  = eng_rd.read_addr;
    assign bus_b.read_en    = eng_rd.read_en & pingpong;
    assign bus_b.write_addr = eng_wr.write_addr;
    assign bus_b.write_en   = eng_wr.write_en & ~pingpong;
    assign bus_b.even_wr    = eng_wr.even_wr;
    assign bus_b.odd_wr     = eng_wr.odd_wr;

    assign eng_rd.even_rd = pingpong ? bus_b.even_rd : bus_a.even_rd;
    assign eng_rd.odd_rd  = pingpong ? bus_b.odd_rd : bus_a.odd_rd;
    assign eng_wr.even_rd = '0;
    assign eng_wr.odd_rd  = '0;

    pair_bank u_bank_a (
        .clock     (clock),
        .port      (bus_a.bank),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_even (load_even),
        .load_odd  (load_odd),
        .host_addr (result_addr),
        .host_even (a_host_even),
        .host_odd  (a_host_odd)
    );

    pair_bank u_bank_b (
        .clock     (clock),
        .port      (bus_b.bank),
        .load_en   (1'b0),
        .load_addr ('0),
        .load_even ('0),
        .load_odd  ('0),
        .host_addr (result_addr),
        .host_even (b_host_even),
        .host_odd  (b_host_odd)
    );

    // After the last pass pingpong names the bank holding the result
    assign result_even = pingpong ? b_host_even : a_host_even;
    assign result_odd  = pingpong ? b_host_odd : a_host_odd;

endmodule

`default_nettype wire

//--- verification/merge_sorter_checker.sv
`default_nettype none
`include "sort_macros.svh"

module merge_sorter_checker (
    input wire logic                        clock,
    input wire logic                        reset,
    input wire logic                        read_en,
    input wire logic                        write_en,
    input wire logic [`BANK_ADDR_WIDTH-1:0] write_addr,
    input wire logic [`BANK_ADDR_WIDTH+1:0] stream_len,
    input wire logic                        busy,
    input wire logic                        done
);

    int unsigned fail_count = 0;

    // No bank traffic once the sort has finished
    no_access_when_done: assert property (
        @(posedge clock) disable iff (reset) done |-> !(read_en || write_en)
    ) else begin
        $error("bank access while done is high");
        fail_count++;
    end

    // Writes stay inside the loaded stream
    write_in_range: assert property (
        @(posedge clock) disable iff (reset)
        write_en |-> ({2'b00, write_addr} < (stream_len >> 1))
    ) else begin
        $error("write address beyond the stream length");
        fail_count++;
    end

    busy_done_exclusive: assert property (
        @(posedge clock) disable iff (reset) !(busy && done)
    ) else begin
        $error("busy and done high together");
        fail_count++;
    end

endmodule

bind merge_phase merge_sorter_checker u_checker (
    .clock      (clock),
    .reset      (reset),
    .read_en    (rd.read_en),
    .write_en   (wr.write_en),
    .write_addr (wr.write_addr),
    .stream_len (stream_len),
    .busy       (busy),
    .done       (done)
);

`default_nettype wire

//--- verification/merge_sorter_tb.sv
`default_nettype none
`include "sort_macros.svh"

module merge_sorter_tb;

    localparam int TW           = `KEY_WIDTH + `PAYLOAD_WIDTH;
    localparam int LW           = `BANK_ADDR_WIDTH + 2;
    localparam int MAX_TUPLES   = 2 * (2 ** `BANK_ADDR_WIDTH);
    localparam int BUSY_TIMEOUT = 4;
    localparam int DONE_TIMEOUT = 20000;

    typedef logic [TW-1:0] word_arr_t [MAX_TUPLES];

    logic                        clock;
    logic                        reset;
    logic                        load_en;
    logic [`BANK_ADDR_WIDTH-1:0] load_addr;
    sort_pkg::tuple_t            load_even;
    sort_pkg::tuple_t            load_odd;
    logic                        start;
    logic [LW-1:0]               stream_len;
    logic                        busy;
    logic                        done;
    logic [`BANK_ADDR_WIDTH-1:0] result_addr;
    sort_pkg::tuple_t            result_even;
    sort_pkg::tuple_t            result_odd;

    integer                      seed;
    int                          error_count;
    bit                          timeout_hit;
    word_arr_t                   stream;
    word_arr_t                   expected;
    logic                        req_valid;
    logic                        cmp_valid;
    logic [`BANK_ADDR_WIDTH-1:0] cmp_addr;
    logic [TW-1:0]               prev_odd;

    merge_sorter u_dut (
        .clock       (clock),
        .reset       (reset),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_even   (load_even),
        .load_odd    (load_odd),
        .start       (start),
        .stream_len  (stream_len),
        .busy        (busy),
        .done        (done),
        .result_addr (result_addr),
        .result_even (result_even),
        .result_odd  (result_odd)
    );

    always #4 clock = ~clock;

    function automatic logic [`PAYLOAD_WIDTH-1:0] payload_of(input logic [`KEY_WIDTH-1:0] key);
        return key * 16'h9e37 + 16'h0011;
    endfunction

    function automatic sort_pkg::tuple_t make_tuple(input logic [`KEY_WIDTH-1:0] key);
        sort_pkg::tuple_t t;
        t.fields.key     = key;
        t.fields.payload = payload_of(key);
        return t;
    endfunction

    // Expected output from an insertion sort of the whole stream by raw value
    function automatic void ref_sort(input word_arr_t data, input int len,
                                     output word_arr_t sorted);
        logic [TW-1:0] item;
        int            j;
        sorted = data;
        for (int i = 1; i < len; i++) begin
            item = sorted[i];
            j    = i - 1;
            while (j >= 0 && sorted[j] > item) begin
                sorted[j + 1] = sorted[j];
                j--;
            end
            sorted[j + 1] = item;
        end
    endfunction

    task automatic report_value(input string name, input logic [TW-1:0] exp,
                                input logic [TW-1:0] act);
        $display("** Error at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    // Each run starts at a random base and climbs by random steps, so it is already sorted
    task automatic build_stream(input int len, input logic [`KEY_WIDTH-1:0] base_mask,
                                input logic [`KEY_WIDTH-1:0] inc_mask);
        logic [`KEY_WIDTH-1:0] key;
        key = '0;
        for (int i = 0; i < len; i++) begin
            if (i % `START_WIDTH == 0) begin
                key = 16'($random(seed)) & base_mask;
            end else begin
                key = key + (16'($random(seed)) & inc_mask);
            end
            stream[i] = make_tuple(key);
        end
    endtask

    task automatic load_stream(input int len);
        for (int a = 0; a < len / 2; a++) begin
            load_en   = 1'b1;
            load_addr = `BANK_ADDR_WIDTH'(a);
            load_even = stream[2 * a];
            load_odd  = stream[2 * a + 1];
            step();
        end
        load_en = 1'b0;
    endtask

    task automatic start_sort(input int len, input bit poke, output bit ok);
        int cycles;
        ok         = 1'b1;
        stream_len = LW'(len);
        start      = 1'b1;
        step();
        start  = 1'b0;
        cycles = 0;
        while (busy !== 1'b1 && cycles < BUSY_TIMEOUT) begin
            step();
            cycles++;
        end
        if (busy !== 1'b1) begin
            $display("Timeout at time %0t: busy never rose after start", $time);
            error_count++;
            timeout_hit = 1'b1;
            ok          = 1'b0;
        end else begin
            if (cycles != 0) begin
                $display("Timing error at time %0t: busy rose %0d cycles late",
                         $time, cycles);
                error_count++;
            end
            cycles = 0;
            while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
                // Strobes while busy reach every pass and must all be ignored
                start = poke && (busy === 1'b1) && (cycles % 8 == 3);
                step();
                cycles++;
            end
            start = 1'b0;
            if (done !== 1'b1) begin
                $display("Timeout at time %0t: done never rose for %0d tuples", $time, len);
                error_count++;
                timeout_hit = 1'b1;
                ok          = 1'b0;
            end else if (busy !== 1'b0) begin
                report_value("busy", TW'(0), TW'(busy));
            end
        end
    endtask

    task automatic read_result(input int len);
        for (int a = 0; a < len / 2; a++) begin
            result_addr = `BANK_ADDR_WIDTH'(a);
            req_valid   = 1'b1;
            step();
        end
        req_valid = 1'b0;
        repeat (2) step();
    endtask

    task automatic run_case(input int len, input logic [`KEY_WIDTH-1:0] base_mask,
                            input logic [`KEY_WIDTH-1:0] inc_mask, input bit poke);
        bit ok;
        build_stream(len, base_mask, inc_mask);
        load_stream(len);
        ref_sort(stream, len, expected);
        start_sort(len, poke, ok);
        if (ok) read_result(len);
    endtask

    // Result data lags the address by a cycle, so check the address presented last cycle
    always @(negedge clock) begin
        if (cmp_valid) begin
            if (result_even.raw !== expected[2 * cmp_addr]) begin
                report_value("result_even", expected[2 * cmp_addr], result_even.raw);
            end
            if (result_odd.raw !== expected[2 * cmp_addr + 1]) begin
                report_value("result_odd", expected[2 * cmp_addr + 1], result_odd.raw);
            end
            if (result_even.raw > result_odd.raw) begin
                $display("Order error at time %0t: pair %0d is not ascending", $time, cmp_addr);
                error_count++;
            end
            if (cmp_addr != 0 && prev_odd > result_even.raw) begin
                $display("Order error at time %0t: pair %0d is below the pair before it",
                         $time, cmp_addr);
                error_count++;
            end
            if (result_odd.fields.payload !== payload_of(result_odd.fields.key)) begin
                report_value("result_odd.payload", TW'(payload_of(result_odd.fields.key)),
                             TW'(result_odd.fields.payload));
            end
            prev_odd = result_odd.raw;
        end
        cmp_valid = req_valid;
        cmp_addr  = result_addr;
    end

    initial begin
        seed        = 78840;
        error_count = 0;
        timeout_hit = 1'b0;
        clock       = 1'b0;
        reset       = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_even   = '0;
        load_odd    = '0;
        start       = 1'b0;
        stream_len  = '0;
        result_addr = '0;
        req_valid   = 1'b0;
        cmp_valid   = 1'b0;
        cmp_addr    = '0;
        prev_odd    = '0;

        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        if (busy !== 1'b0) report_value("busy", TW'(0), TW'(busy));
        if (done !== 1'b0) report_value("done", TW'(0), TW'(done));
        repeat (20) step();
        if (done !== 1'b0) report_value("done", TW'(0), TW'(done));

        // Four random runs, then a clamped tail with starts while busy,
        // then a full bank of duplicates ending in bank b
        run_case(64, 16'h7fff, 16'h01ff, 1'b0);
        if (!timeout_hit) run_case(48, 16'h7fff, 16'h01ff, 1'b1);
        if (!timeout_hit) run_case(128, 16'h000f, 16'h0003, 1'b0);

        $display("Summary: %0d check errors, %0d assertion failures",
                 error_count, u_dut.u_merge.u_checker.fail_count);
        if (error_count == 0 && u_dut.u_merge.u_checker.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/sort_pkg.sv
src/bank_if.sv
src/pair_bank.sv
src/merge_phase.sv
src/merge_sorter.sv
verification/merge_sorter_checker.sv
verification/merge_sorter_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := merge_sorter_tb
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
RUN_FLAGS := +verilator+error+limit+1000
FAIL_MSG  := Test failures found
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
